/* logic/iq_stream_config.svh */
////////////////////////////////////////////////////////////////////////////
// build-time settings for the I/Q stream packer
// IQS_REDUCE_PRECISION must stay within 0..4 so a word never loses sign
// IQS_BURST_LEN must be 2 or more, tlast marks every IQS_BURST_LEN-th beat
// values are global to the build, one setting for every instance
////////////////////////////////////////////////////////////////////////////

`ifndef IQS_STREAM_CONFIG_SVH
`define IQS_STREAM_CONFIG_SVH

// raw converter sample width, two's complement
`define IQS_SAMPLE_BITS 12

// low bits dropped by the arithmetic right shift
`define IQS_REDUCE_PRECISION 0

// 1 mirrors the word order inside a beat
`define IQS_REVERSE_DATA 0

// handshakes per burst, the last one carries tlast
`define IQS_BURST_LEN 4

`endif

/* logic/iq_stream_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types for the I/Q stream packer
// word and beat widths are fixed at 16 and 128 bits
// burst counter width follows IQS_BURST_LEN from the config header
////////////////////////////////////////////////////////////////////////////

`include "iq_stream_config.svh"

package iq_stream_pkg;

  // receiver has four channels, each with an I and a Q sample
  localparam int unsigned LANE_COUNT = 4;
  localparam int unsigned WORDS_PER_BEAT = 2 * LANE_COUNT;

  // output word width after sign extension
  localparam int unsigned WORD_BITS = 16;

  // burst position counter width
  localparam int unsigned BURST_COUNT_BITS = $clog2(`IQS_BURST_LEN);

  // one raw converter sample
  typedef logic [`IQS_SAMPLE_BITS-1:0] iq_sample_t;

  // one sign-extended output word
  typedef logic [WORD_BITS-1:0] lane_word_t;

  // one AXI-stream beat, word k at bits 16k+15:16k
  typedef logic [WORDS_PER_BEAT*WORD_BITS-1:0] axis_beat_t;

  // position inside the current burst
  typedef logic [BURST_COUNT_BITS-1:0] burst_count_t;

endpackage

/* logic/iq_lanes_if.sv */
////////////////////////////////////////////////////////////////////////////
// lane bundle from the converter side into the packer
// index n of valid, data_i and data_q belongs to channel n
// no back-pressure, every cycle with a valid high is a sample instant
////////////////////////////////////////////////////////////////////////////

interface iq_lanes_if import iq_stream_pkg::*; ();

  // per-channel valid
  logic [LANE_COUNT-1:0] valid;

  // per-channel samples
  iq_sample_t data_i [LANE_COUNT];
  iq_sample_t data_q [LANE_COUNT];

  // driven by the top level
  modport src (
    output valid,
    output data_i,
    output data_q
  );

  // read by the lane packer
  modport snk (
    input valid,
    input data_i,
    input data_q
  );

endinterface

/* logic/iq_lane_packer.sv */
////////////////////////////////////////////////////////////////////////////
// packs eight I/Q samples into one 128-bit beat
// all eight words are packed, whichever lane valid is high
// latency one cycle, one beat per cycle, no stall input
// beat holds its last value between sample instants
////////////////////////////////////////////////////////////////////////////

`include "iq_stream_config.svh"

module iq_lane_packer import iq_stream_pkg::*; (
  input  logic       m_axis_clk,
  input  logic       rst,
  iq_lanes_if.snk    lanes,
  output axis_beat_t beat,
  output logic       beat_strobe
);

  // bits dropped by the precision shift
  localparam int unsigned SHIFT = `IQS_REDUCE_PRECISION;

  // sign bits added on top of a shifted sample
  localparam int unsigned EXT_BITS = WORD_BITS - `IQS_SAMPLE_BITS;

  logic       sample_instant;
  lane_word_t natural_word [WORDS_PER_BEAT];
  axis_beat_t beat_next;

  // arithmetic shift, then sign extension to a full word
  function automatic lane_word_t format_sample(input iq_sample_t sample);
    iq_sample_t shifted;
    shifted = $signed(sample) >>> SHIFT;
    return {{EXT_BITS{shifted[`IQS_SAMPLE_BITS-1]}}, shifted};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // sample instant
  ////////////////////////////////////////////////////////////////////////////

  // any channel valid starts a beat
  assign sample_instant = |lanes.valid;

  ////////////////////////////////////////////////////////////////////////////
  // word formatting and ordering
  ////////////////////////////////////////////////////////////////////////////

  // natural order: q3 i3 q2 i2 q1 i1 q0 i0 from word 0 upward
  for (genvar k = 0; k < WORDS_PER_BEAT; k++) begin : g_natural
    localparam int LANE = LANE_COUNT - 1 - k / 2;

    if (k % 2 == 0) begin : g_q
      assign natural_word[k] = format_sample(lanes.data_q[LANE]);
    end else begin : g_i
      assign natural_word[k] = format_sample(lanes.data_i[LANE]);
    end
  end

  // reversal mirrors the whole word order
  for (genvar k = 0; k < WORDS_PER_BEAT; k++) begin : g_place
    if (`IQS_REVERSE_DATA != 0) begin : g_rev
      assign beat_next[k*WORD_BITS +: WORD_BITS] = natural_word[WORDS_PER_BEAT-1-k];
    end else begin : g_fwd
      assign beat_next[k*WORD_BITS +: WORD_BITS] = natural_word[k];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////////////////////

  // strobe is high for exactly the cycle after a sample instant
  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      beat_strobe <= 1'b0;
    end else begin
      beat_strobe <= sample_instant;
    end
  end

  // payload only, loaded together with the strobe
  always_ff @(posedge m_axis_clk) begin
    if (sample_instant) begin
      beat <= beat_next;
    end
  end

  // framer qualifies tdata with this strobe
  a_strobe_known: assert property (
    @(posedge m_axis_clk) disable iff (rst)
    !$isunknown(beat_strobe)
  );

endmodule

/* logic/axis_beat_framer.sv */
////////////////////////////////////////////////////////////////////////////
// AXI-stream master stage for packed beats
// a beat that arrives during a stall replaces the held one (data is lost)
// and overrun pulses for one cycle afterwards
// tlast marks every IQS_BURST_LEN-th handshake counted from reset
// tvalid and tdata registered, tlast decoded from registers
////////////////////////////////////////////////////////////////////////////

`include "iq_stream_config.svh"

module axis_beat_framer import iq_stream_pkg::*; (
  input  logic       m_axis_clk,
  input  logic       rst,
  input  axis_beat_t beat,
  input  logic       beat_strobe,
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  output axis_beat_t m_axis_tdata,
  output logic       m_axis_tlast,
  output logic       overrun
);

  // counter value of the final beat in a burst
  localparam burst_count_t LAST_COUNT = burst_count_t'(`IQS_BURST_LEN - 1);

  logic         handshake;
  logic         stalled;
  logic         end_burst;
  burst_count_t burst_count;

  assign handshake = m_axis_tvalid & m_axis_tready;
  assign stalled   = m_axis_tvalid & ~m_axis_tready;
  assign end_burst = (burst_count == LAST_COUNT);

  ////////////////////////////////////////////////////////////////////////////
  // valid and data
  ////////////////////////////////////////////////////////////////////////////

  // new beat wins over a handshake in the same cycle
  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      m_axis_tvalid <= 1'b0;
    end else if (beat_strobe) begin
      m_axis_tvalid <= 1'b1;
    end else if (handshake) begin
      m_axis_tvalid <= 1'b0;
    end
  end

  // held while stalled unless a newer beat overwrites it
  always_ff @(posedge m_axis_clk) begin
    if (beat_strobe) begin
      m_axis_tdata <= beat;
    end
  end

  // beat replaced before the sink took it
  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      overrun <= 1'b0;
    end else begin
      overrun <= beat_strobe & stalled;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // burst counting
  ////////////////////////////////////////////////////////////////////////////

  // advances on handshakes only, wraps after the last beat
  always_ff @(posedge m_axis_clk) begin
    if (rst) begin
      burst_count <= '0;
    end else if (handshake) begin
      if (end_burst) begin
        burst_count <= '0;
      end else begin
        burst_count <= burst_count + 1'b1;
      end
    end
  end

  assign m_axis_tlast = m_axis_tvalid & end_burst;

  // a stalled beat is never withdrawn, and keeps its tlast
  a_stall_holds: assert property (
    @(posedge m_axis_clk) disable iff (rst)
    stalled |=> m_axis_tvalid && $stable(m_axis_tlast)
  );

endmodule

/* logic/ad9361_axis_packer.sv */
////////////////////////////////////////////////////////////////////////////
// AD9361-style four-channel receiver to 128-bit AXI-stream
// single clock, converter side has no back-pressure
// latency two cycles from sample instant to tvalid
// overrun flags a beat dropped by a stalled sink
////////////////////////////////////////////////////////////////////////////

module ad9361_axis_packer import iq_stream_pkg::*; (
  input  logic       m_axis_clk,
  input  logic       rst,
  input  logic       valid_0,
  input  logic       valid_1,
  input  logic       valid_2,
  input  logic       valid_3,
  input  iq_sample_t data_i0,
  input  iq_sample_t data_i1,
  input  iq_sample_t data_i2,
  input  iq_sample_t data_i3,
  input  iq_sample_t data_q0,
  input  iq_sample_t data_q1,
  input  iq_sample_t data_q2,
  input  iq_sample_t data_q3,
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  output logic       m_axis_tlast,
  output axis_beat_t m_axis_tdata,
  output logic       overrun
);

  axis_beat_t beat;
  logic       beat_strobe;

  iq_lanes_if lanes ();

  // channel n goes to lane index n
  assign lanes.valid = {valid_3, valid_2, valid_1, valid_0};

  assign lanes.data_i[0] = data_i0;
  assign lanes.data_i[1] = data_i1;
  assign lanes.data_i[2] = data_i2;
  assign lanes.data_i[3] = data_i3;

  assign lanes.data_q[0] = data_q0;
  assign lanes.data_q[1] = data_q1;
  assign lanes.data_q[2] = data_q2;
  assign lanes.data_q[3] = data_q3;

  // samples to beats
  iq_lane_packer i_iq_lane_packer (
    .m_axis_clk  (m_axis_clk),
    .rst         (rst),
    .lanes       (lanes.snk),
    .beat        (beat),
    .beat_strobe (beat_strobe)
  );

  // beats to stream
  axis_beat_framer i_axis_beat_framer (
    .m_axis_clk    (m_axis_clk),
    .rst           (rst),
    .beat          (beat),
    .beat_strobe   (beat_strobe),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .overrun       (overrun)
  );

endmodule

/* dv/tb_ad9361_axis_packer.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the four-channel I/Q to AXI-stream packer
// expected beats come from the beat layout rule and the config header
// outputs are checked every cycle at the falling clock edge
// random rows use a fixed seed, the run is bounded by a watchdog
////////////////////////////////////////////////////////////////////////////

`include "iq_stream_config.svh"

module tb_ad9361_axis_packer import iq_stream_pkg::*; ();

  localparam int FIXED_ROWS      = 17;
  localparam int NUM_ROWS        = 32;
  localparam int BURST_LEN       = `IQS_BURST_LEN;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 20 + 200;

  // one table row, samples are q3 q2 q1 q0 i3 i2 i1 i0 from the top
  typedef struct packed {
    logic [3:0]       valid;
    iq_sample_t [7:0] smp;
    logic [7:0]       ready;
    logic [3:0]       cycles;
  } stim_row_t;

  logic       m_axis_clk;
  logic       rst;
  logic       valid_0;
  logic       valid_1;
  logic       valid_2;
  logic       valid_3;
  iq_sample_t data_i0;
  iq_sample_t data_i1;
  iq_sample_t data_i2;
  iq_sample_t data_i3;
  iq_sample_t data_q0;
  iq_sample_t data_q1;
  iq_sample_t data_q2;
  iq_sample_t data_q3;
  logic       m_axis_tvalid;
  logic       m_axis_tready;
  logic       m_axis_tlast;
  axis_beat_t m_axis_tdata;
  logic       overrun;

  stim_row_t  rows [NUM_ROWS];
  integer     seed;
  int         err_count;
  int         check_count;
  int         delivered;
  int         overruns;

  // reference model state, mirrors the DUT outputs after the last edge
  axis_beat_t exp_q [$];
  logic       exp_tvalid;
  logic       exp_overrun;
  logic       strobe_pending;
  axis_beat_t pending_beat;
  int         burst_pos;

  ad9361_axis_packer i_ad9361_axis_packer (
    .m_axis_clk    (m_axis_clk),
    .rst           (rst),
    .valid_0       (valid_0),
    .valid_1       (valid_1),
    .valid_2       (valid_2),
    .valid_3       (valid_3),
    .data_i0       (data_i0),
    .data_i1       (data_i1),
    .data_i2       (data_i2),
    .data_i3       (data_i3),
    .data_q0       (data_q0),
    .data_q1       (data_q1),
    .data_q2       (data_q2),
    .data_q3       (data_q3),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tdata  (m_axis_tdata),
    .overrun       (overrun)
  );

  always #2 m_axis_clk = ~m_axis_clk;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // two's complement value, floor division by 2^shift, then 16 bits
  function automatic lane_word_t expected_word(input iq_sample_t s);
    int v;
    v = int'(s);
    if (s[`IQS_SAMPLE_BITS-1]) begin
      v = v - (1 << `IQS_SAMPLE_BITS);
    end
    v = v >>> `IQS_REDUCE_PRECISION;
    return lane_word_t'(v);
  endfunction

  // positions 0..7 hold q3 i3 q2 i2 q1 i1 q0 i0, mirrored when reversed
  function automatic axis_beat_t expected_beat(input iq_sample_t [7:0] smp);
    axis_beat_t b;
    lane_word_t w;
    int         k;
    int         ch;
    int         pos;
    b = '0;
    for (k = 0; k < 8; k++) begin
      ch = 3 - k / 2;
      if (k % 2 == 0) begin
        w = expected_word(smp[4 + ch]);
      end else begin
        w = expected_word(smp[ch]);
      end
      pos = (`IQS_REVERSE_DATA != 0) ? 7 - k : k;
      b[pos*16 +: 16] = w;
    end
    return b;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic count_failure(input string what);
    err_count++;
    $display("t=%0t %s", $time, what);
  endtask

  task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("ERR %s exp=%h act=%h t=%0t", name, exp, act, $time);
    end
  endtask

  task automatic check_last(input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("ERR m_axis_tlast exp=%h act=%h t=%0t", exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("ERR %s exp=%h act=%h t=%0t", name, exp, act, $time);
    end
  endtask

  // compare, then advance the model to the state after the next edge
  task automatic step_model();
    logic hs;
    logic stall;
    check_flag("m_axis_tvalid", exp_tvalid, m_axis_tvalid);
    check_flag("overrun", exp_overrun, overrun);
    check_last(exp_tvalid && (burst_pos == BURST_LEN - 1), m_axis_tlast);
    if (exp_tvalid && exp_q.size() != 0) begin
      check_beat("m_axis_tdata", exp_q[0], m_axis_tdata);
    end
    if (overrun === 1'b1) begin
      overruns++;
    end
    if (rst) begin
      exp_q.delete();
      exp_tvalid     = 1'b0;
      exp_overrun    = 1'b0;
      strobe_pending = 1'b0;
      burst_pos      = 0;
      return;
    end
    hs    = m_axis_tvalid && m_axis_tready;
    stall = exp_tvalid && !m_axis_tready;
    if (hs) begin
      if (exp_q.size() == 0) begin
        count_failure("handshake seen with no beat expected on the bus");
      end else begin
        void'(exp_q.pop_front());
      end
      delivered++;
      burst_pos = (burst_pos == BURST_LEN - 1) ? 0 : burst_pos + 1;
    end
    // a strobed beat during a stall replaces the held one
    exp_overrun = strobe_pending && stall;
    if (strobe_pending) begin
      if (stall && exp_q.size() != 0) begin
        void'(exp_q.pop_back());
      end
      exp_q.push_back(pending_beat);
      exp_tvalid = 1'b1;
    end else if (hs) begin
      exp_tvalid = 1'b0;
    end
    strobe_pending = valid_0 | valid_1 | valid_2 | valid_3;
    if (strobe_pending) begin
      pending_beat = expected_beat({data_q3, data_q2, data_q1, data_q0,
                                    data_i3, data_i2, data_i1, data_i0});
    end
  endtask

  always @(negedge m_axis_clk) begin
    step_model();
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_table();
    int r;
    int s;
    // single lanes, same samples, so four identical beats
    rows[0]  = '{4'b0001, 96'h5a3_0c7_e12_7f0_321_8ab_04d_fa9, 8'hff, 4'd4};
    rows[1]  = '{4'b0010, 96'h5a3_0c7_e12_7f0_321_8ab_04d_fa9, 8'hff, 4'd4};
    rows[2]  = '{4'b0100, 96'h5a3_0c7_e12_7f0_321_8ab_04d_fa9, 8'hff, 4'd4};
    rows[3]  = '{4'b1000, 96'h5a3_0c7_e12_7f0_321_8ab_04d_fa9, 8'hff, 4'd4};
    // extreme and negative samples
    rows[4]  = '{4'b1111, 96'h000_ffe_800_7ff_001_7ff_fff_800, 8'hff, 4'd4};
    rows[5]  = '{4'b0011, 96'hfff_800_7ff_fff_800_800_7ff_fff, 8'hff, 4'd4};
    // stall, then a second beat replaces the held one
    rows[6]  = '{4'b1111, 96'h111_222_333_444_555_666_777_888, 8'h00, 4'd3};
    rows[7]  = '{4'b0100, 96'h999_aaa_bbb_ccc_ddd_eee_f00_0ff, 8'hf8, 4'd6};
    // long stall without replacement, then idle
    rows[8]  = '{4'b1000, 96'h0a0_b0b_c0c_d0d_e0e_f0f_101_202, 8'hc0, 4'd8};
    rows[9]  = '{4'b0000, 96'h000_000_000_000_000_000_000_000, 8'hff, 4'd5};
    // a sample instant on every cycle
    rows[10] = '{4'b1111, 96'h010_020_030_040_050_060_070_080, 8'hff, 4'd1};
    rows[11] = '{4'b1111, 96'h801_802_803_804_805_806_807_808, 8'hff, 4'd1};
    rows[12] = '{4'b0001, 96'hf01_e02_d03_c04_b05_a06_907_808, 8'hff, 4'd1};
    rows[13] = '{4'b1010, 96'h7ff_800_7ff_800_7ff_800_7ff_800, 8'hff, 4'd1};
    rows[14] = '{4'b1111, 96'h123_456_789_abc_def_fed_cba_987, 8'hff, 4'd1};
    rows[15] = '{4'b0110, 96'h00f_0f0_f00_fff_001_010_100_111, 8'hff, 4'd1};
    rows[16] = '{4'b0000, 96'h000_000_000_000_000_000_000_000, 8'hff, 4'd4};
    for (r = FIXED_ROWS; r < NUM_ROWS; r++) begin
      rows[r].valid = 4'($random(seed));
      for (s = 0; s < 8; s++) begin
        rows[r].smp[s] = iq_sample_t'($random(seed));
      end
      rows[r].ready  = 8'($random(seed));
      rows[r].cycles = 4'(1 + ($unsigned($random(seed)) % 8));
    end
  endtask

  // valids only on the first cycle of a row, tready follows the pattern
  task automatic apply_cycle(input stim_row_t row, input int c);
    valid_0       <= (c == 0) ? row.valid[0] : 1'b0;
    valid_1       <= (c == 0) ? row.valid[1] : 1'b0;
    valid_2       <= (c == 0) ? row.valid[2] : 1'b0;
    valid_3       <= (c == 0) ? row.valid[3] : 1'b0;
    data_i0       <= row.smp[0];
    data_i1       <= row.smp[1];
    data_i2       <= row.smp[2];
    data_i3       <= row.smp[3];
    data_q0       <= row.smp[4];
    data_q1       <= row.smp[5];
    data_q2       <= row.smp[6];
    data_q3       <= row.smp[7];
    m_axis_tready <= row.ready[c];
  endtask

  initial begin
    m_axis_clk     = 1'b0;
    rst            = 1'b1;
    valid_0        = 1'b0;
    valid_1        = 1'b0;
    valid_2        = 1'b0;
    valid_3        = 1'b0;
    data_i0        = '0;
    data_i1        = '0;
    data_i2        = '0;
    data_i3        = '0;
    data_q0        = '0;
    data_q1        = '0;
    data_q2        = '0;
    data_q3        = '0;
    m_axis_tready  = 1'b0;
    seed           = 88681;
    err_count      = 0;
    check_count    = 0;
    delivered      = 0;
    overruns       = 0;
    exp_tvalid     = 1'b0;
    exp_overrun    = 1'b0;
    strobe_pending = 1'b0;
    pending_beat   = '0;
    burst_pos      = 0;
    load_table();

    repeat (8) @(posedge m_axis_clk);
    rst <= 1'b0;

    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < rows[r].cycles; c++) begin
        @(posedge m_axis_clk);
        apply_cycle(rows[r], c);
      end
    end

    // drain whatever is still held or in flight
    @(posedge m_axis_clk);
    valid_0       <= 1'b0;
    valid_1       <= 1'b0;
    valid_2       <= 1'b0;
    valid_3       <= 1'b0;
    m_axis_tready <= 1'b1;
    repeat (2) @(posedge m_axis_clk);
    while (exp_q.size() != 0 || exp_tvalid) begin
      @(posedge m_axis_clk);
    end
    repeat (3) @(posedge m_axis_clk);
    if (delivered == 0) begin
      count_failure("no beat was delivered during the whole run");
    end

    $display("errors %0d in %0d checks, %0d beats delivered, %0d overruns",
             err_count, check_count, delivered, overruns);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge m_axis_clk);
    $display("timeout after %0d cycles, the stimulus did not finish", WATCHDOG_CYCLES);
    $display("errors %0d in %0d checks, %0d beats delivered, %0d overruns",
             err_count, check_count, delivered, overruns);
    $display("Checks failed");
    $finish;
  end

endmodule

/* ad9361_axis_packer.f */
+incdir+logic
logic/iq_stream_pkg.sv
logic/iq_lanes_if.sv
logic/iq_lane_packer.sv
logic/axis_beat_framer.sv
logic/ad9361_axis_packer.sv
dv/tb_ad9361_axis_packer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the packer testbench with Verilator.
# The run passes only when the testbench prints its pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ad9361_axis_packer \
  -f ad9361_axis_packer.f

out=$(./obj_dir/Vtb_ad9361_axis_packer)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  exit 0
else
  exit 1
fi
